// ==== sim.f ====
+incdir+rtl
rtl/gps_channel_pkg.sv
rtl/ca_code_gen.sv
rtl/correlator_bank.sv
rtl/power_pipeline.sv
rtl/track_loop_state.sv
rtl/gps_channel.sv
dv/gps_channel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gps_channel_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/gps_channel_tb.sv ====
`timescale 1ns/1ps
`include "gps_channel_defines.svh"

module gps_channel_tb;

   import gps_channel_pkg::*;

   localparam int PERIOD_SAMPLES   = `SAMPLE_COUNT_MAX + 1;
   localparam int SAMPLES_PER_CHIP = (1 << `CA_PHASE_WIDTH) / `CA_PHASE_INC_NOMINAL;
   localparam int IDLE_PERIODS     = 1;
   localparam int CODE_PERIODS     = 2;
   localparam int LOOP_PERIODS     = 3;
   // Availability is high at least every other cycle, so duty is at least one half.
   localparam longint WATCHDOG_NS =
      (longint'(IDLE_PERIODS + CODE_PERIODS + LOOP_PERIODS) * PERIOD_SAMPLES * 2
       + 2000) * 10;

   logic                            clk;
   logic                            i_rst;
   logic                            i_start;
   logic                            i_data_available;
   sample_t                         i_data;
   logic [4:0]                      i_prn;
   logic [`IQ_WIDTH-1:0]            i_iq_prompt_k;
   logic [`CARRIER_PHASE_WIDTH-1:0] i_doppler_inc_kp1;
   logic [`W_DF_WIDTH-1:0]          i_w_df_kp1;
   logic [`W_DF_DOT_WIDTH-1:0]      i_w_df_dot_kp1;
   logic [`CA_PHASE_WIDTH-1:0]      i_ca_dphi_kp1;
   logic                            i_tracking_ready;
   logic [`CS_WIDTH-1:0]            o_code_shift;
   logic                            o_ca_prompt;
   logic                            o_acc_valid;
   acc_t                            o_i_prompt_k;
   acc_t                            o_q_prompt_k;
   logic                            o_i2q2_valid;
   i2q2_t                           o_i2q2_early;
   i2q2_t                           o_i2q2_prompt;
   i2q2_t                           o_i2q2_late;
   acc_t                            o_i_prompt_km1;
   acc_t                            o_q_prompt_km1;
   logic [`IQ_WIDTH-1:0]            o_iq_prompt_km1;
   logic [`W_DF_WIDTH-1:0]          o_w_df_k;
   logic [`W_DF_DOT_WIDTH-1:0]      o_w_df_dot_k;
   logic [`CARRIER_PHASE_WIDTH-1:0] o_doppler_inc;
   logic [`CA_PHASE_WIDTH-1:0]      o_ca_phase_offset;

   // Reference model state.
   int                              errors;
   int                              seed;
   bit                              odd;
   bit                              started;
   bit                              code_check_en;
   int                              sample_n;
   logic                            ca_seq [1023];
   logic                            exp_acc_valid;
   logic [4:0]                      acc_hist;
   i2q2_t                           exp_power;
   logic                            exp_prompt;
   logic [`CS_WIDTH-1:0]            exp_shift;
   acc_t                            exp_i_km1;
   acc_t                            exp_q_km1;
   logic [`IQ_WIDTH-1:0]            exp_iq_km1;
   logic [`W_DF_WIDTH-1:0]          exp_w_df;
   logic [`W_DF_DOT_WIDTH-1:0]      exp_w_df_dot;
   logic [`CARRIER_PHASE_WIDTH-1:0] exp_doppler;
   logic [`CA_PHASE_WIDTH-1:0]      exp_offset;
   bit                              first_ready;

   gps_channel DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the expected dumps were seen.");
      $display("Finished with errors");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("CHECK FAILED t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
   endtask

   function automatic i2q2_t power_of(input acc_t i_val, input acc_t q_val);
      int i_int;
      int q_int;
      i_int = i_val;
      q_int = q_val;
      return i2q2_t'(i_int * i_int + q_int * q_int);
   endfunction

   // PRN 1 Gold code, G2 taps 2 and 6.
   initial begin
      logic [10:1] g1;
      logic [10:1] g2;
      g1 = '1;
      g2 = '1;
      for (int k = 0; k < 1023; k++) begin
         ca_seq[k] = g1[10] ^ g2[2] ^ g2[6];
         g1 = {g1[9:1], g1[3] ^ g1[10]};
         g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   end

   assign exp_shift  = `CS_WIDTH'((sample_n / SAMPLES_PER_CHIP) % 1023);
   assign exp_prompt = (sample_n == 0) ? 1'b0 :
                       ca_seq[((sample_n - 1) / SAMPLES_PER_CHIP) % 1023];

   always @(posedge clk) begin
      if (i_rst) begin
         started       <= 1'b0;
         sample_n      <= 0;
         exp_acc_valid <= 1'b0;
         acc_hist      <= '0;
         exp_power     <= '0;
      end else begin
         acc_hist      <= {acc_hist[3:0], o_acc_valid};
         exp_acc_valid <= started && i_data_available && !i_start &&
                          (sample_n % PERIOD_SAMPLES == PERIOD_SAMPLES - 1);
         if (o_acc_valid) begin
            exp_power <= power_of(o_i_prompt_k, o_q_prompt_k);
         end
         if (i_start) begin
            started  <= 1'b1;
            sample_n <= 0;
         end else if (started && i_data_available) begin
            sample_n <= sample_n + 1;
         end
      end
   end

   // Loop history as the external filter expects it.
   always @(posedge clk) begin
      if (i_rst || i_start) begin
         exp_i_km1    <= '0;
         exp_q_km1    <= '0;
         exp_iq_km1   <= `IQ_WIDTH'd1;
         exp_w_df     <= '0;
         exp_w_df_dot <= '0;
         exp_doppler  <= '0;
         exp_offset   <= '0;
         first_ready  <= 1'b1;
      end else if (i_tracking_ready) begin
         exp_i_km1    <= o_i_prompt_k;
         exp_q_km1    <= o_q_prompt_k;
         exp_iq_km1   <= i_iq_prompt_k;
         exp_w_df     <= i_w_df_kp1;
         exp_w_df_dot <= i_w_df_dot_kp1;
         exp_offset   <= exp_offset + i_ca_dphi_kp1;
         first_ready  <= 1'b0;
         if (!first_ready) begin
            exp_doppler <= i_doppler_inc_kp1;
         end
      end
   end

   a_acc_valid: assert property (@(posedge clk) disable iff (i_rst)
      o_acc_valid == exp_acc_valid)
      else report_mismatch("o_acc_valid", $sampled(o_acc_valid), $sampled(exp_acc_valid));

   a_i2q2_valid: assert property (@(posedge clk) disable iff (i_rst)
      o_i2q2_valid == acc_hist[4])
      else report_mismatch("o_i2q2_valid", $sampled(o_i2q2_valid), $sampled(acc_hist[4]));

   a_idle_power: assert property (@(posedge clk) disable iff (i_rst)
      !started |-> (o_i2q2_early | o_i2q2_prompt | o_i2q2_late) == '0)
      else report_mismatch("o_i2q2_early|prompt|late",
                           $sampled(o_i2q2_early | o_i2q2_prompt | o_i2q2_late), 0);

   a_prompt_power: assert property (@(posedge clk) disable iff (i_rst)
      o_i2q2_valid |-> o_i2q2_prompt == exp_power)
      else report_mismatch("o_i2q2_prompt", $sampled(o_i2q2_prompt), $sampled(exp_power));

   a_code_chip: assert property (@(posedge clk) disable iff (i_rst)
      code_check_en && started && i_data_available && !i_start |->
      o_ca_prompt == exp_prompt)
      else report_mismatch("o_ca_prompt", $sampled(o_ca_prompt), $sampled(exp_prompt));

   a_code_shift: assert property (@(posedge clk) disable iff (i_rst)
      code_check_en && started && i_data_available && !i_start |->
      o_code_shift == exp_shift)
      else report_mismatch("o_code_shift", $sampled(o_code_shift), $sampled(exp_shift));

   a_i_km1: assert property (@(posedge clk) disable iff (i_rst) o_i_prompt_km1 == exp_i_km1)
      else report_mismatch("o_i_prompt_km1", $sampled(o_i_prompt_km1), $sampled(exp_i_km1));

   a_q_km1: assert property (@(posedge clk) disable iff (i_rst) o_q_prompt_km1 == exp_q_km1)
      else report_mismatch("o_q_prompt_km1", $sampled(o_q_prompt_km1), $sampled(exp_q_km1));

   a_iq_km1: assert property (@(posedge clk) disable iff (i_rst) o_iq_prompt_km1 == exp_iq_km1)
      else report_mismatch("o_iq_prompt_km1", $sampled(o_iq_prompt_km1), $sampled(exp_iq_km1));

   a_w_df: assert property (@(posedge clk) disable iff (i_rst) o_w_df_k == exp_w_df)
      else report_mismatch("o_w_df_k", $sampled(o_w_df_k), $sampled(exp_w_df));

   a_w_df_dot: assert property (@(posedge clk) disable iff (i_rst) o_w_df_dot_k == exp_w_df_dot)
      else report_mismatch("o_w_df_dot_k", $sampled(o_w_df_dot_k), $sampled(exp_w_df_dot));

   a_doppler: assert property (@(posedge clk) disable iff (i_rst) o_doppler_inc == exp_doppler)
      else report_mismatch("o_doppler_inc", $sampled(o_doppler_inc), $sampled(exp_doppler));

   a_offset: assert property (@(posedge clk) disable iff (i_rst)
      o_ca_phase_offset == exp_offset)
      else report_mismatch("o_ca_phase_offset", $sampled(o_ca_phase_offset),
                           $sampled(exp_offset));

   // One falling edge of stimulus. Samples arrive on odd calls and randomly otherwise.
   task automatic drive_cycle(input logic start, input logic ready);
      logic [31:0] rnd;
      @(negedge clk);
      rnd               = $random(seed);
      i_start           = start;
      i_data_available  = !start && (odd || rnd[0]);
      i_data            = sample_t'(rnd[3:1]);
      i_tracking_ready  = ready;
      odd               = !odd;
      if (ready) begin
         i_iq_prompt_k     = $random(seed);
         i_doppler_inc_kp1 = `CARRIER_PHASE_WIDTH'($random(seed));
         i_w_df_kp1        = `W_DF_WIDTH'($random(seed));
         i_w_df_dot_kp1    = `W_DF_DOT_WIDTH'($random(seed));
         i_ca_dphi_kp1     = `CA_PHASE_WIDTH'(rnd[15:8]);
      end
   endtask

   // Runs until the given number of dumps, answering each one when asked to.
   task automatic run_periods(input int periods, input bit answer_loop);
      int seen;
      bit ready_due;
      seen      = 0;
      ready_due = 1'b0;
      while (seen < periods) begin
         drive_cycle(1'b0, ready_due);
         ready_due = answer_loop && o_acc_valid;
         if (o_acc_valid) begin
            seen++;
         end
      end
      repeat (12) begin
         drive_cycle(1'b0, ready_due);
         ready_due = 1'b0;
      end
   endtask

   initial begin
      int idle_samples;
      errors            = 0;
      seed              = 32'h4a08d107;
      odd               = 1'b0;
      code_check_en     = 1'b0;
      i_rst             = 1'b1;
      i_start           = 1'b0;
      i_data_available  = 1'b0;
      i_data            = '0;
      i_prn             = 5'd0;
      i_iq_prompt_k     = '0;
      i_doppler_inc_kp1 = '0;
      i_w_df_kp1        = '0;
      i_w_df_dot_kp1    = '0;
      i_ca_dphi_kp1     = '0;
      i_tracking_ready  = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;

      // A full period of samples and more before any start must not dump.
      idle_samples = 0;
      while (idle_samples <= IDLE_PERIODS * PERIOD_SAMPLES) begin
         drive_cycle(1'b0, 1'b0);
         if (i_data_available) begin
            idle_samples++;
         end
      end

      // Code check over two periods, which crosses one code wrap.
      code_check_en = 1'b1;
      drive_cycle(1'b1, 1'b0);
      run_periods(CODE_PERIODS, 1'b0);

      // Loop filter answers after every dump.
      code_check_en = 1'b0;
      drive_cycle(1'b1, 1'b0);
      run_periods(LOOP_PERIODS, 1'b1);

      $display("Run complete, %0d check(s) failed", errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== rtl/gps_channel.sv ====
`timescale 1ns/1ps
`include "gps_channel_defines.svh"

module gps_channel (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_start,
   input  logic                            i_data_available,
   input  gps_channel_pkg::sample_t        i_data,
   input  logic [4:0]                      i_prn,
   input  logic [`IQ_WIDTH-1:0]            i_iq_prompt_k,
   input  logic [`CARRIER_PHASE_WIDTH-1:0] i_doppler_inc_kp1,
   input  logic [`W_DF_WIDTH-1:0]          i_w_df_kp1,
   input  logic [`W_DF_DOT_WIDTH-1:0]      i_w_df_dot_kp1,
   input  logic [`CA_PHASE_WIDTH-1:0]      i_ca_dphi_kp1,
   input  logic                            i_tracking_ready,
   output logic [`CS_WIDTH-1:0]            o_code_shift,
   output logic                            o_ca_prompt,
   output logic                            o_acc_valid,
   output gps_channel_pkg::acc_t           o_i_prompt_k,
   output gps_channel_pkg::acc_t           o_q_prompt_k,
   output logic                            o_i2q2_valid,
   output gps_channel_pkg::i2q2_t          o_i2q2_early,
   output gps_channel_pkg::i2q2_t          o_i2q2_prompt,
   output gps_channel_pkg::i2q2_t          o_i2q2_late,
   output gps_channel_pkg::acc_t           o_i_prompt_km1,
   output gps_channel_pkg::acc_t           o_q_prompt_km1,
   output logic [`IQ_WIDTH-1:0]            o_iq_prompt_km1,
   output logic [`W_DF_WIDTH-1:0]          o_w_df_k,
   output logic [`W_DF_DOT_WIDTH-1:0]      o_w_df_dot_k,
   output logic [`CARRIER_PHASE_WIDTH-1:0] o_doppler_inc,
   output logic [`CA_PHASE_WIDTH-1:0]      o_ca_phase_offset
);

   import gps_channel_pkg::*;

   logic dump;
   logic ca_early;
   logic ca_late;
   acc_t i_early;
   acc_t q_early;
   acc_t i_late;
   acc_t q_late;

   ca_code_gen u_code (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_start          (i_start),
      .i_data_available (i_data_available),
      .i_prn            (i_prn),
      .i_phase_offset   (o_ca_phase_offset),
      .o_ca_early       (ca_early),
      .o_ca_prompt      (o_ca_prompt),
      .o_ca_late        (ca_late),
      .o_code_shift     (o_code_shift)
   );

   correlator_bank u_corr (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_start          (i_start),
      .i_data_available (i_data_available),
      .i_data           (i_data),
      .i_doppler_inc    (o_doppler_inc),
      .i_ca_early       (ca_early),
      .i_ca_prompt      (o_ca_prompt),
      .i_ca_late        (ca_late),
      .i_dump           (dump),
      .o_acc_valid      (o_acc_valid),
      .o_i_early        (i_early),
      .o_q_early        (q_early),
      .o_i_prompt       (o_i_prompt_k),
      .o_q_prompt       (o_q_prompt_k),
      .o_i_late         (i_late),
      .o_q_late         (q_late)
   );

   power_pipeline u_power (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_acc_valid   (o_acc_valid),
      .i_i_early     (i_early),
      .i_q_early     (q_early),
      .i_i_prompt    (o_i_prompt_k),
      .i_q_prompt    (o_q_prompt_k),
      .i_i_late      (i_late),
      .i_q_late      (q_late),
      .o_i2q2_valid  (o_i2q2_valid),
      .o_i2q2_early  (o_i2q2_early),
      .o_i2q2_prompt (o_i2q2_prompt),
      .o_i2q2_late   (o_i2q2_late)
   );

   track_loop_state u_loop (
      .clk               (clk),
      .i_rst             (i_rst),
      .i_start           (i_start),
      .i_data_available  (i_data_available),
      .i_acc_valid       (o_acc_valid),
      .i_i_prompt        (o_i_prompt_k),
      .i_q_prompt        (o_q_prompt_k),
      .i_tracking_ready  (i_tracking_ready),
      .i_iq_prompt_k     (i_iq_prompt_k),
      .i_doppler_inc_kp1 (i_doppler_inc_kp1),
      .i_w_df_kp1        (i_w_df_kp1),
      .i_w_df_dot_kp1    (i_w_df_dot_kp1),
      .i_ca_dphi_kp1     (i_ca_dphi_kp1),
      .o_dump            (dump),
      .o_doppler_inc     (o_doppler_inc),
      .o_ca_phase_offset (o_ca_phase_offset),
      .o_i_prompt_km1    (o_i_prompt_km1),
      .o_q_prompt_km1    (o_q_prompt_km1),
      .o_iq_prompt_km1   (o_iq_prompt_km1),
      .o_w_df_k          (o_w_df_k),
      .o_w_df_dot_k      (o_w_df_dot_k)
   );

endmodule

// ==== rtl/track_loop_state.sv ====
`timescale 1ns/1ps
`include "gps_channel_defines.svh"

module track_loop_state (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_start,
   input  logic                            i_data_available,
   input  logic                            i_acc_valid,
   input  gps_channel_pkg::acc_t           i_i_prompt,
   input  gps_channel_pkg::acc_t           i_q_prompt,
   input  logic                            i_tracking_ready,
   input  logic [`IQ_WIDTH-1:0]            i_iq_prompt_k,
   input  logic [`CARRIER_PHASE_WIDTH-1:0] i_doppler_inc_kp1,
   input  logic [`W_DF_WIDTH-1:0]          i_w_df_kp1,
   input  logic [`W_DF_DOT_WIDTH-1:0]      i_w_df_dot_kp1,
   input  logic [`CA_PHASE_WIDTH-1:0]      i_ca_dphi_kp1,
   output logic                            o_dump,
   output logic [`CARRIER_PHASE_WIDTH-1:0] o_doppler_inc,
   output logic [`CA_PHASE_WIDTH-1:0]      o_ca_phase_offset,
   output gps_channel_pkg::acc_t           o_i_prompt_km1,
   output gps_channel_pkg::acc_t           o_q_prompt_km1,
   output logic [`IQ_WIDTH-1:0]            o_iq_prompt_km1,
   output logic [`W_DF_WIDTH-1:0]          o_w_df_k,
   output logic [`W_DF_DOT_WIDTH-1:0]      o_w_df_dot_k
);

   logic [`SAMPLE_COUNT_WIDTH-1:0] sample_count;
   logic                           last_sample;
   logic                           tracking;
   logic                           ignore_doppler;
   logic                           result_pending;

   assign last_sample = (sample_count == `SAMPLE_COUNT_WIDTH'(`SAMPLE_COUNT_MAX));
   assign o_dump      = tracking && i_data_available && !i_start && last_sample;

   // Dump period counter and result bookkeeping.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         tracking       <= 1'b0;
         sample_count   <= '0;
         result_pending <= 1'b0;
      end else if (i_start) begin
         tracking       <= 1'b1;
         sample_count   <= '0;
         result_pending <= 1'b0;
      end else begin
         if (i_data_available) begin
            sample_count <= last_sample ? '0 : sample_count + 1'b1;
         end
         if (i_acc_valid) begin
            result_pending <= 1'b1;
         end else if (i_tracking_ready) begin
            result_pending <= 1'b0;
         end
      end
   end

   // Loop history. I*Q starts at one so the loop never divides by zero.
   always_ff @(posedge clk) begin
      if (i_rst || i_start) begin
         o_i_prompt_km1    <= '0;
         o_q_prompt_km1    <= '0;
         o_iq_prompt_km1   <= `IQ_WIDTH'd1;
         o_w_df_k          <= '0;
         o_w_df_dot_k      <= '0;
         o_doppler_inc     <= '0;
         o_ca_phase_offset <= '0;
         ignore_doppler    <= 1'b1;
      end else if (i_tracking_ready) begin
         o_i_prompt_km1    <= i_i_prompt;
         o_q_prompt_km1    <= i_q_prompt;
         o_iq_prompt_km1   <= i_iq_prompt_k;
         o_w_df_k          <= i_w_df_kp1;
         o_w_df_dot_k      <= i_w_df_dot_kp1;
         // First FLL result after a start is not trusted.
         ignore_doppler    <= 1'b0;
         if (!ignore_doppler) begin
            o_doppler_inc <= i_doppler_inc_kp1;
         end
         // DLL reports a change, carrier loops a new value.
         o_ca_phase_offset <= o_ca_phase_offset + i_ca_dphi_kp1;
      end
   end

   // Loop filter answers only after a fresh dump.
   a_ready_after_dump: assert property (@(posedge clk) disable iff (i_rst)
      i_tracking_ready |-> result_pending);

endmodule

// ==== rtl/power_pipeline.sv ====
`timescale 1ns/1ps

module power_pipeline (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_acc_valid,
   input  gps_channel_pkg::acc_t  i_i_early,
   input  gps_channel_pkg::acc_t  i_q_early,
   input  gps_channel_pkg::acc_t  i_i_prompt,
   input  gps_channel_pkg::acc_t  i_q_prompt,
   input  gps_channel_pkg::acc_t  i_i_late,
   input  gps_channel_pkg::acc_t  i_q_late,
   output logic                   o_i2q2_valid,
   output gps_channel_pkg::i2q2_t o_i2q2_early,
   output gps_channel_pkg::i2q2_t o_i2q2_prompt,
   output gps_channel_pkg::i2q2_t o_i2q2_late
);

   import gps_channel_pkg::*;

   acc_mag_t mag_i [3];
   acc_mag_t mag_q [3];
   logic     issue_busy;
   tap_e     issue_tap;
   logic     sq_valid;
   tap_e     sq_tap;
   i2q2_t    i2_sq;
   i2q2_t    q2_sq;

   function automatic acc_mag_t magnitude(input acc_t value);
      return acc_mag_t'(value < 0 ? -value : value);
   endfunction

   // Magnitudes held while the three taps are issued.
   always_ff @(posedge clk) begin
      if (i_acc_valid) begin
         mag_i[TAP_EARLY]  <= magnitude(i_i_early);
         mag_q[TAP_EARLY]  <= magnitude(i_q_early);
         mag_i[TAP_PROMPT] <= magnitude(i_i_prompt);
         mag_q[TAP_PROMPT] <= magnitude(i_q_prompt);
         mag_i[TAP_LATE]   <= magnitude(i_i_late);
         mag_q[TAP_LATE]   <= magnitude(i_q_late);
      end
   end

   // Shared squarer pair, one tap per cycle.
   always_ff @(posedge clk) begin
      i2_sq <= mag_i[issue_tap] * mag_i[issue_tap];
      q2_sq <= mag_q[issue_tap] * mag_q[issue_tap];
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         issue_busy    <= 1'b0;
         issue_tap     <= TAP_EARLY;
         sq_valid      <= 1'b0;
         sq_tap        <= TAP_EARLY;
         o_i2q2_valid  <= 1'b0;
         o_i2q2_early  <= '0;
         o_i2q2_prompt <= '0;
         o_i2q2_late   <= '0;
      end else begin
         if (i_acc_valid) begin
            issue_busy <= 1'b1;
            issue_tap  <= TAP_EARLY;
         end else if (issue_busy) begin
            issue_busy <= (issue_tap != TAP_LATE);
            issue_tap  <= (issue_tap == TAP_LATE) ? TAP_EARLY : tap_e'(issue_tap + 2'd1);
         end
         sq_valid <= issue_busy;
         sq_tap   <= issue_tap;
         // Sum stage writes straight into the tap's register.
         if (sq_valid) begin
            case (sq_tap)
               TAP_EARLY:  o_i2q2_early  <= i2_sq + q2_sq;
               TAP_PROMPT: o_i2q2_prompt <= i2_sq + q2_sq;
               default:    o_i2q2_late   <= i2_sq + q2_sq;
            endcase
         end
         o_i2q2_valid <= sq_valid && (sq_tap == TAP_LATE);
      end
   end

   // No back-pressure, so dumps must be spaced past the busy window.
   a_no_overlap: assert property (@(posedge clk) disable iff (i_rst)
      i_acc_valid |=> !i_acc_valid [*5]);

   a_result_latency: assert property (@(posedge clk) disable iff (i_rst)
      i_acc_valid |-> ##5 o_i2q2_valid);

endmodule

// ==== rtl/correlator_bank.sv ====
`timescale 1ns/1ps
`include "gps_channel_defines.svh"

module correlator_bank (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_start,
   input  logic                            i_data_available,
   input  gps_channel_pkg::sample_t        i_data,
   input  logic [`CARRIER_PHASE_WIDTH-1:0] i_doppler_inc,
   input  logic                            i_ca_early,
   input  logic                            i_ca_prompt,
   input  logic                            i_ca_late,
   input  logic                            i_dump,
   output logic                            o_acc_valid,
   output gps_channel_pkg::acc_t           o_i_early,
   output gps_channel_pkg::acc_t           o_q_early,
   output gps_channel_pkg::acc_t           o_i_prompt,
   output gps_channel_pkg::acc_t           o_q_prompt,
   output gps_channel_pkg::acc_t           o_i_late,
   output gps_channel_pkg::acc_t           o_q_late
);

   import gps_channel_pkg::*;

   // Eight-step carrier, indexed by the top three phase bits.
   localparam carrier_t COS_TABLE [8] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };
   localparam carrier_t SIN_TABLE [8] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

   logic [`CARRIER_PHASE_WIDTH-1:0]    carrier_phase;
   logic [2:0]                         carrier_idx;
   carrier_t                           carrier_cos;
   carrier_t                           carrier_sin;
   logic signed [2*`SAMPLE_WIDTH-1:0]  mix_i;
   logic signed [2*`SAMPLE_WIDTH-1:0]  mix_q;
   logic [2:0]                         code_bit;
   acc_t                               acc_i [3];
   acc_t                               acc_q [3];
   acc_t                               sum_i [3];
   acc_t                               sum_q [3];
   acc_t                               dump_i [3];
   acc_t                               dump_q [3];

   assign carrier_idx = carrier_phase[`CARRIER_PHASE_WIDTH-1 -: 3];
   assign carrier_cos = COS_TABLE[carrier_idx];
   assign carrier_sin = SIN_TABLE[carrier_idx];

   // Doppler wipe-off, shared by all taps.
   assign mix_i = i_data * carrier_cos;
   assign mix_q = i_data * carrier_sin;

   assign code_bit = {i_ca_late, i_ca_prompt, i_ca_early};

   // A code bit of one flips the sign of the product.
   always_comb begin
      for (int t = 0; t < 3; t++) begin
         sum_i[t] = code_bit[t] ? acc_i[t] - acc_t'(mix_i) : acc_i[t] + acc_t'(mix_i);
         sum_q[t] = code_bit[t] ? acc_q[t] - acc_t'(mix_q) : acc_q[t] + acc_t'(mix_q);
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carrier_phase <= '0;
         o_acc_valid   <= 1'b0;
         for (int t = 0; t < 3; t++) begin
            acc_i[t]  <= '0;
            acc_q[t]  <= '0;
            dump_i[t] <= '0;
            dump_q[t] <= '0;
         end
      end else begin
         o_acc_valid <= i_dump;
         if (i_start) begin
            carrier_phase <= '0;
            for (int t = 0; t < 3; t++) begin
               acc_i[t] <= '0;
               acc_q[t] <= '0;
            end
         end else if (i_data_available) begin
            carrier_phase <= carrier_phase + i_doppler_inc;
            // Dumping sample is part of the period it closes.
            for (int t = 0; t < 3; t++) begin
               acc_i[t] <= i_dump ? '0 : sum_i[t];
               acc_q[t] <= i_dump ? '0 : sum_q[t];
               if (i_dump) begin
                  dump_i[t] <= sum_i[t];
                  dump_q[t] <= sum_q[t];
               end
            end
         end
      end
   end

   assign o_i_early  = dump_i[0];
   assign o_q_early  = dump_q[0];
   assign o_i_prompt = dump_i[1];
   assign o_q_prompt = dump_q[1];
   assign o_i_late   = dump_i[2];
   assign o_q_late   = dump_q[2];

   // The dump counter only closes a period on a real sample.
   a_dump_on_sample: assert property (@(posedge clk) disable iff (i_rst)
      i_dump |-> i_data_available);

endmodule

// ==== rtl/ca_code_gen.sv ====
`timescale 1ns/1ps
`include "gps_channel_defines.svh"

module ca_code_gen (
   input  logic                       clk,
   input  logic                       i_rst,
   input  logic                       i_start,
   input  logic                       i_data_available,
   // PRN number minus one.
   input  logic [4:0]                 i_prn,
   input  logic [`CA_PHASE_WIDTH-1:0] i_phase_offset,
   output logic                       o_ca_early,
   output logic                       o_ca_prompt,
   output logic                       o_ca_late,
   output logic [`CS_WIDTH-1:0]       o_code_shift
);

   // G2 phase selector tap pairs, one byte {tap_a, tap_b} per PRN.
   localparam logic [7:0] G2_TAPS [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2a, 8'h18, 8'h29,
      8'h3a, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9a,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8a, 8'h16, 8'h27, 8'h38, 8'h49
   };

   logic [10:1]                g1;
   logic [10:1]                g2;
   logic [3:0]                 g2_tap_a;
   logic [3:0]                 g2_tap_b;
   logic [`CA_PHASE_WIDTH-1:0] code_phase;
   logic [`CA_PHASE_WIDTH-1:0] code_inc;
   logic [`CA_PHASE_WIDTH:0]   code_phase_next;
   logic                       chip_step;
   logic                       code_wrap;

   assign {g2_tap_a, g2_tap_b} = G2_TAPS[i_prn];

   // Code NCO, the carry out marks a chip boundary.
   assign code_inc        = `CA_PHASE_INC_NOMINAL + i_phase_offset;
   assign code_phase_next = {1'b0, code_phase} + {1'b0, code_inc};
   assign chip_step       = code_phase_next[`CA_PHASE_WIDTH];
   assign code_wrap       = chip_step &&
                            (o_code_shift == `CS_WIDTH'(`CA_CODE_LENGTH - 1));

   // Gold code chip for the current state.
   assign o_ca_early = g1[10] ^ g2[g2_tap_a] ^ g2[g2_tap_b];

   always_ff @(posedge clk) begin
      if (i_rst || i_start) begin
         code_phase   <= '0;
         g1           <= '1;
         g2           <= '1;
         o_code_shift <= '0;
         o_ca_prompt  <= 1'b0;
         o_ca_late    <= 1'b0;
      end else if (i_data_available) begin
         code_phase  <= code_phase_next[`CA_PHASE_WIDTH-1:0];
         // Taps trail by one sample each.
         o_ca_prompt <= o_ca_early;
         o_ca_late   <= o_ca_prompt;
         if (code_wrap) begin
            g1           <= '1;
            g2           <= '1;
            o_code_shift <= '0;
         end else if (chip_step) begin
            g1           <= {g1[9:1], g1[3] ^ g1[10]};
            g2           <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
            o_code_shift <= o_code_shift + 1'b1;
         end
      end
   end

   // Chip index never reaches the code length.
   a_chip_range: assert property (@(posedge clk) disable iff (i_rst)
      o_code_shift < `CA_CODE_LENGTH);

endmodule

// ==== rtl/gps_channel_pkg.sv ====
`include "gps_channel_defines.svh"

package gps_channel_pkg;

   // Raw signed front-end sample.
   typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

   // Correlator sums and their magnitudes.
   typedef logic signed [`ACC_WIDTH-1:0] acc_t;
   typedef logic [`ACC_WIDTH-2:0] acc_mag_t;

   typedef logic [`I2Q2_WIDTH-1:0] i2q2_t;

   // Carrier table level, -2 to +2.
   typedef logic signed [2:0] carrier_t;

   // Correlator tap, also the issue order of the power pipeline.
   typedef enum logic [1:0] {
      TAP_EARLY  = 2'd0,
      TAP_PROMPT = 2'd1,
      TAP_LATE   = 2'd2
   } tap_e;

endpackage

// ==== rtl/gps_channel_defines.svh ====
`ifndef GPS_CHANNEL_DEFINES_SVH
`define GPS_CHANNEL_DEFINES_SVH

// Sample, correlator and power widths.
`define SAMPLE_WIDTH 3
`define ACC_WIDTH 16
`define I2Q2_WIDTH 32

// NCO phase accumulators.
`define CARRIER_PHASE_WIDTH 24
`define CA_PHASE_WIDTH 24

// 16 samples per chip at 16.368 MHz, so one overflow per chip.
`define CA_PHASE_INC_NOMINAL 24'h100000

// C/A code format.
`define CA_CODE_LENGTH 1023
`define CS_WIDTH 10

// One 1 ms dump period at 16.368 MHz.
`define SAMPLE_COUNT_MAX 16367
`define SAMPLE_COUNT_WIDTH 14

// Words exchanged with the external loop filter.
`define W_DF_WIDTH 16
`define W_DF_DOT_WIDTH 16
`define IQ_WIDTH 32

`endif
